/* rtl/dcache_pkg.sv */
package dcache_pkg;

    typedef logic [31:0] word_t;

    // cache geometry
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 8;
    localparam int SET_W       = $clog2(NUM_SETS);
    localparam int BLOCK_WORDS = 2;
    localparam int BLKOFF_W    = $clog2(BLOCK_WORDS);
    localparam int BYTOFF_W    = 2;
    localparam int TAG_W       = 32 - SET_W - BLKOFF_W - BYTOFF_W;

    typedef logic way_t;

    // word address split into cache fields
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    idx;
        logic [BLKOFF_W-1:0] blkoff;
        logic [BYTOFF_W-1:0] bytoff;
    } dcache_addr_t;

    // one block, 92 bits
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        logic [TAG_W-1:0]             tag;
        word_t [BLOCK_WORDS-1:0]      data;
    } dcache_frame_t;

endpackage

/* rtl/dcache_store_if.sv */
`timescale 1ns/1ps

interface dcache_store_if
    import dcache_pkg::*;
();

    // store side
    logic                miss;
    way_t                victim_way;
    dcache_frame_t       sel_frame;

    // controller side
    logic                busy;
    logic [SET_W-1:0]    sel_idx;
    way_t                sel_way;
    logic                fill_en;
    logic [BLKOFF_W-1:0] fill_word;
    word_t               fill_data;
    logic                clean_en;

    modport store (
        output miss, victim_way, sel_frame,
        input  busy, sel_idx, sel_way, fill_en, fill_word, fill_data, clean_en
    );

    modport ctrl (
        input  miss, victim_way, sel_frame,
        output busy, sel_idx, sel_way, fill_en, fill_word, fill_data, clean_en
    );

endinterface

/* rtl/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store
    import dcache_pkg::*;
(
    input  logic          CLK,
    input  logic          n_rst,
    input  logic          dmemren,
    input  logic          dmemwen,
    input  word_t         dmemaddr,
    input  word_t         dmemstore,
    output word_t         dmemload,
    output logic          dhit,
    dcache_store_if.store sif
);

    dcache_frame_t       frames [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] lru;       // way to replace next, per set

    dcache_addr_t        req;
    logic                req_en;
    logic [NUM_WAYS-1:0] way_hit;
    way_t                hit_way;
    logic                hit;
    logic                wr_hit;

    assign req    = dcache_addr_t'(dmemaddr);
    assign req_en = dmemren | dmemwen;

    // tag compare on both ways of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = frames[w][req.idx].valid &&
                         (frames[w][req.idx].tag == req.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_t'(way_hit[1]);

    // no answers while the controller owns the arrays
    assign dhit     = req_en && hit && !sif.busy;
    assign wr_hit   = dhit && dmemwen;
    assign dmemload = frames[hit_way][req.idx].data[req.blkoff];

    assign sif.miss       = req_en && !hit && !sif.busy;
    assign sif.victim_way = lru[req.idx];
    assign sif.sel_frame  = frames[sif.sel_way][sif.sel_idx];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    frames[w][s] <= '0;
                end
            end
            lru <= '0;
        end else begin
            if (dhit) begin
                lru[req.idx] <= ~hit_way;   // hit way becomes MRU
            end

            if (wr_hit) begin
                frames[hit_way][req.idx].data[req.blkoff] <= dmemstore;
                frames[hit_way][req.idx].dirty            <= 1'b1;
            end

            if (sif.fill_en) begin
                frames[sif.sel_way][sif.sel_idx].data[sif.fill_word] <= sif.fill_data;
                if (sif.fill_word == BLKOFF_W'(BLOCK_WORDS - 1)) begin
                    // block complete
                    frames[sif.sel_way][sif.sel_idx].valid <= 1'b1;
                    frames[sif.sel_way][sif.sel_idx].dirty <= 1'b0;
                    frames[sif.sel_way][sif.sel_idx].tag   <= req.tag;
                    lru[sif.sel_idx]                       <= ~sif.sel_way;
                end else begin
                    // half filled, keep it from matching
                    frames[sif.sel_way][sif.sel_idx].valid <= 1'b0;
                end
            end

            if (sif.clean_en) begin
                frames[sif.sel_way][sif.sel_idx].dirty <= 1'b0;
            end
        end
    end

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic         CLK,
    input  logic         n_rst,
    input  logic         halt,
    input  word_t        dmemaddr,
    output logic         dren,
    output logic         dwen,
    output word_t        daddr,
    output word_t        dstore,
    input  word_t        dload,
    input  logic         dwait,
    output logic         flushed,
    dcache_store_if.ctrl sif
);

    typedef enum logic [3:0] {
        idle,
        wb_word0,
        wb_word1,
        fill_word0,
        fill_word1,
        flush_check,
        flush_word0,
        flush_word1,
        done
    } state_t;

    state_t           state, next_state;
    logic [SET_W-1:0] flush_idx, next_flush_idx;
    way_t             flush_way, next_flush_way;
    logic             next_dren, next_dwen;
    word_t            next_daddr, next_dstore;
    dcache_addr_t     req;
    logic             flushing;
    logic             flush_last;
    logic             advance;

    // word address of one block word
    function automatic word_t blk_addr(input logic [TAG_W-1:0]    tag,
                                       input logic [SET_W-1:0]    idx,
                                       input logic [BLKOFF_W-1:0] blkoff);
        dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blkoff;
        a.bytoff = '0;
        return word_t'(a);
    endfunction

    assign req        = dcache_addr_t'(dmemaddr);
    assign flushing   = state inside {flush_check, flush_word0, flush_word1, done};
    assign flush_last = (flush_idx == SET_W'(NUM_SETS - 1)) && flush_way;

    assign sif.busy      = (state != idle) || halt;
    assign sif.sel_idx   = flushing ? flush_idx : req.idx;
    assign sif.sel_way   = flushing ? flush_way : sif.victim_way;
    assign sif.fill_data = dload;
    assign flushed       = (state == done);

    always_comb begin
        next_state     = state;
        next_flush_idx = flush_idx;
        next_flush_way = flush_way;
        next_dren      = dren;     // strobes and bus hold by default
        next_dwen      = dwen;
        next_daddr     = daddr;
        next_dstore    = dstore;
        sif.fill_en    = 1'b0;
        sif.fill_word  = '0;
        sif.clean_en   = 1'b0;
        advance        = 1'b0;

        case (state)
            idle: begin
                if (halt) begin
                    next_state = flush_check;
                end else if (sif.miss) begin
                    if (sif.sel_frame.dirty) begin
                        next_state  = wb_word0;
                        next_dwen   = 1'b1;
                        next_daddr  = blk_addr(sif.sel_frame.tag, sif.sel_idx, '0);
                        next_dstore = sif.sel_frame.data[0];
                    end else begin
                        next_state = fill_word0;
                        next_dren  = 1'b1;
                        next_daddr = blk_addr(req.tag, req.idx, '0);
                    end
                end
            end
            wb_word0, flush_word0: begin
                if (!dwait) begin
                    next_state  = (state == wb_word0) ? wb_word1 : flush_word1;
                    next_daddr  = blk_addr(sif.sel_frame.tag, sif.sel_idx, BLKOFF_W'(1));
                    next_dstore = sif.sel_frame.data[1];
                end
            end
            wb_word1: begin
                if (!dwait) begin
                    sif.clean_en = 1'b1;
                    next_state   = fill_word0;
                    next_dwen    = 1'b0;
                    next_dren    = 1'b1;
                    next_daddr   = blk_addr(req.tag, req.idx, '0);
                end
            end
            fill_word0: begin
                if (!dwait) begin
                    sif.fill_en = 1'b1;
                    next_state  = fill_word1;
                    next_daddr  = blk_addr(req.tag, req.idx, BLKOFF_W'(1));
                end
            end
            fill_word1: begin
                if (!dwait) begin
                    sif.fill_en   = 1'b1;
                    sif.fill_word = BLKOFF_W'(1);
                    next_state    = idle;   // request is looked up again
                    next_dren     = 1'b0;
                end
            end
            flush_check: begin
                if (sif.sel_frame.dirty) begin
                    next_state  = flush_word0;
                    next_dwen   = 1'b1;
                    next_daddr  = blk_addr(sif.sel_frame.tag, sif.sel_idx, '0);
                    next_dstore = sif.sel_frame.data[0];
                end else begin
                    advance = 1'b1;
                end
            end
            flush_word1: begin
                if (!dwait) begin
                    sif.clean_en = 1'b1;
                    next_dwen    = 1'b0;
                    advance      = 1'b1;
                end
            end
            default: ;  // done, wait for reset
        endcase

        // step to the next way, then the next set
        if (advance) begin
            if (flush_last) begin
                next_state = done;
            end else begin
                next_state     = flush_check;
                next_flush_way = ~flush_way;
                if (flush_way) begin
                    next_flush_idx = flush_idx + SET_W'(1);
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= idle;
            flush_idx <= '0;
            flush_way <= 1'b0;
            dren      <= 1'b0;
            dwen      <= 1'b0;
            daddr     <= '0;
            dstore    <= '0;
        end else begin
            state     <= next_state;
            flush_idx <= next_flush_idx;
            flush_way <= next_flush_way;
            dren      <= next_dren;
            dwen      <= next_dwen;
            daddr     <= next_daddr;
            dstore    <= next_dstore;
        end
    end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  n_rst,
    input  logic  halt,

    // processor side
    input  logic  dmemren,
    input  logic  dmemwen,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output word_t dmemload,
    output logic  dhit,
    output logic  flushed,

    // memory side
    output logic  dren,
    output logic  dwen,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);

    dcache_store_if sif ();

    // tag/data arrays and hit path
    dcache_store store_i (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .dmemren   (dmemren),
        .dmemwen   (dmemwen),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .sif       (sif.store)
    );

    // miss and flush sequencing
    dcache_ctrl ctrl_i (
        .CLK      (CLK),
        .n_rst    (n_rst),
        .halt     (halt),
        .dmemaddr (dmemaddr),
        .dren     (dren),
        .dwen     (dwen),
        .daddr    (daddr),
        .dstore   (dstore),
        .dload    (dload),
        .dwait    (dwait),
        .flushed  (flushed),
        .sif      (sif.ctrl)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic CLK
);

    initial CLK = 1'b0;

    always #5 CLK = ~CLK;   // 10 ns period

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic  CLK,
    input  logic  n_rst,
    input  logic  dren,
    input  logic  dwen,
    input  word_t daddr,
    input  word_t dstore,
    output word_t dload,
    output logic  dwait
);

    word_t      mem [word_t];   // sparse word store
    word_t      wr_addr_q [$];  // log of write transfers
    word_t      wr_data_q [$];
    int         rd_count = 0;
    logic [1:0] wait_left;

    assign dwait = (dren || dwen) && (wait_left != 2'd0);

    // words never loaded fall back to an address pattern
    always_comb begin
        if (mem.exists(daddr)) begin
            dload = mem[daddr];
        end else begin
            dload = ~daddr ^ {daddr[15:0], daddr[31:16]};
        end
    end

    always @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            wait_left <= 2'd0;
        end else if ((dren || dwen) && wait_left == 2'd0) begin
            if (dwen) begin
                mem[daddr] = dstore;
                wr_addr_q.push_back(daddr);
                wr_data_q.push_back(dstore);
            end else begin
                rd_count++;
            end
            wait_left <= 2'($urandom_range(3, 0));   // delay of the next transfer
        end else if (dren || dwen) begin
            wait_left <= wait_left - 2'd1;
        end
    end

endmodule

/* bench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int SEED      = 32'hf6a9_804a;
    localparam int MISS_MAX  = 24;          // dirty miss, worst dwait
    localparam int FLUSH_MAX = 16 * 12;
    localparam int NUM_RAND  = 40;
    localparam int NUM_REQ   = 60;
    localparam int LIMIT_NS  = 2 * 10 * (5 + NUM_REQ * MISS_MAX + FLUSH_MAX);

    logic  CLK, n_rst, halt, dmemren, dmemwen, dhit, flushed;
    logic  dren, dwen, dwait;
    word_t dmemaddr, dmemstore, dmemload, daddr, dstore, dload;

    word_t shadow [word_t];     // reference memory
    bit    dirty_blk [word_t];  // blocks the cache should hold dirty
    int    log_seen = 0;
    string test_name;

    tb_clock clk_i (.CLK(CLK));

    dcache_top dut_i (.*);

    mem_model mem_i (.*);

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error in %s: %s", test_name, what);
        stop_run();
    endtask

    task automatic check_word(input string test, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", test, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", test, exp, act);
            stop_run();
        end
    endtask

    function automatic word_t make_addr(input int unsigned tag, input int unsigned idx,
                                        input int unsigned off);
        dcache_addr_t a;
        a.tag    = TAG_W'(tag);
        a.idx    = SET_W'(idx);
        a.blkoff = BLKOFF_W'(off);
        a.bytoff = '0;
        return word_t'(a);
    endfunction

    function automatic word_t block_of(input word_t a);
        return {a[31:3], 3'b000};
    endfunction

    // random block contents, same in memory and shadow
    task automatic ensure_loaded(input word_t a);
        word_t b;
        b = block_of(a);
        if (!shadow.exists(b)) begin
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                shadow[b + 4 * w]    = $urandom;
                mem_i.mem[b + 4 * w] = shadow[b + 4 * w];
            end
        end
    endtask

    // every logged write must come from a dirty block
    task automatic note_writebacks();
        word_t a;
        while (log_seen < mem_i.wr_addr_q.size()) begin
            a = mem_i.wr_addr_q[log_seen];
            if (!dirty_blk.exists(block_of(a))) begin
                report_error($sformatf("clean block %h was written back", block_of(a)));
            end
            check_word(test_name, shadow[a], mem_i.wr_data_q[log_seen]);
            if (a[2]) begin
                dirty_blk.delete(block_of(a));   // both words out
            end
            log_seen++;
        end
    endtask

    task automatic access(input logic wr, input word_t a, input word_t wdata,
                          output logic first_cycle);
        int cycles;
        cycles = 0;
        ensure_loaded(a);
        dmemren   = !wr;
        dmemwen   = wr;
        dmemaddr  = a;
        dmemstore = wdata;
        @(negedge CLK);
        while (!dhit) begin
            cycles++;
            if (cycles > MISS_MAX) begin
                report_error($sformatf("request to %h never hit", a));
            end
            @(negedge CLK);
        end
        first_cycle = (cycles == 0);
        if (!wr) begin
            check_word(test_name, shadow[a], dmemload);
        end
        @(posedge CLK);
        #1;
        dmemren = 1'b0;
        dmemwen = 1'b0;
        note_writebacks();
        if (wr) begin
            shadow[a]              = wdata;
            dirty_blk[block_of(a)] = 1'b1;
        end
    endtask

    task automatic read_miss_fill();
        word_t a;
        logic  first;
        test_name = "read_miss";
        a = make_addr(32'h10, 1, 0);
        access(1'b0, a, '0, first);
        check_bit(test_name, 1'b0, first);
        access(1'b0, a + 4, '0, first);   // other word of the block
        check_bit(test_name, 1'b1, first);
    endtask

    task automatic write_hit_no_traffic();
        word_t a;
        int    n;
        logic  first;
        test_name = "write_hit";
        a = make_addr(32'h10, 1, 0);
        n = mem_i.wr_addr_q.size();
        access(1'b1, a, $urandom, first);
        check_bit(test_name, 1'b1, first);
        access(1'b0, a, '0, first);
        check_bit(test_name, 1'b1, first);
        check_word(test_name, word_t'(n), word_t'(mem_i.wr_addr_q.size()));
    endtask

    task automatic dirty_eviction();
        word_t x;
        int    n;
        logic  first;
        test_name = "evict_dirty";
        x = make_addr(32'h20, 2, 0);
        access(1'b1, x, $urandom, first);
        access(1'b1, make_addr(32'h21, 2, 1), $urandom, first);
        n = mem_i.wr_addr_q.size();
        access(1'b1, make_addr(32'h22, 2, 0), $urandom, first);
        check_word(test_name, word_t'(n + 2), word_t'(mem_i.wr_addr_q.size()));
        check_word(test_name, x, mem_i.wr_addr_q[n]);
        check_word(test_name, x + 4, mem_i.wr_addr_q[n + 1]);
    endtask

    task automatic lru_replacement();
        word_t a;
        int    rd_n;
        int    wr_n;
        logic  first;
        test_name = "lru_order";
        a = make_addr(32'h40, 3, 0);
        access(1'b0, a, '0, first);
        access(1'b0, make_addr(32'h41, 3, 1), '0, first);
        access(1'b0, a, '0, first);
        check_bit(test_name, 1'b1, first);
        rd_n = mem_i.rd_count;
        wr_n = mem_i.wr_addr_q.size();
        access(1'b0, make_addr(32'h42, 3, 0), '0, first);   // should evict the second block
        check_word(test_name, word_t'(rd_n + 2), word_t'(mem_i.rd_count));
        rd_n = mem_i.rd_count;
        access(1'b0, a + 4, '0, first);
        check_bit(test_name, 1'b1, first);
        check_word(test_name, word_t'(rd_n), word_t'(mem_i.rd_count));
        check_word(test_name, word_t'(wr_n), word_t'(mem_i.wr_addr_q.size()));
    endtask

    task automatic random_traffic();
        word_t a;
        logic  wr;
        logic  first;
        test_name = "random";
        repeat (NUM_RAND) begin
            a  = make_addr(32'h30 + $urandom_range(3, 0), $urandom_range(7, 0),
                           $urandom_range(1, 0));
            wr = 1'($urandom_range(1, 0));
            access(wr, a, $urandom, first);
        end
    endtask

    task automatic halt_flush_dirty();
        int   cycles;
        logic first;
        test_name = "halt_flush";
        access(1'b1, make_addr(32'h50, 5, 1), $urandom, first);
        access(1'b1, make_addr(32'h51, 6, 0), $urandom, first);
        access(1'b0, make_addr(32'h52, 7, 0), '0, first);   // stays clean
        halt   = 1'b1;
        cycles = 0;
        @(negedge CLK);
        while (!flushed) begin
            cycles++;
            if (cycles > FLUSH_MAX) begin
                report_error("flushed never rose after halt");
            end
            @(negedge CLK);
        end
        note_writebacks();
        check_word(test_name, '0, word_t'(dirty_blk.num()));
        check_word(test_name, word_t'(shadow.num()), word_t'(mem_i.mem.num()));
        foreach (shadow[k]) begin
            check_word(test_name, shadow[k], mem_i.mem[k]);
        end
        repeat (3) @(negedge CLK);
        check_bit(test_name, 1'b1, flushed);   // held until reset
    endtask

    always @(negedge CLK) begin
        if (n_rst && dren && dwen) begin
            report_error("dren and dwen were high together");
        end
    end

    initial begin
        #(LIMIT_NS);
        report_error("the run timed out");
    end

    initial begin
        void'($urandom(SEED));
        n_rst     = 1'b0;
        halt      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        test_name = "reset";
        repeat (5) @(posedge CLK);
        #1;
        n_rst = 1'b1;
        check_bit(test_name, 1'b0, dren);
        check_bit(test_name, 1'b0, dwen);
        check_bit(test_name, 1'b0, dhit);
        check_bit(test_name, 1'b0, flushed);
        read_miss_fill();
        write_hit_no_traffic();
        dirty_eviction();
        lru_replacement();
        random_traffic();
        halt_flush_dirty();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* project.f */
rtl/dcache_pkg.sv
rtl/dcache_store_if.sv
rtl/dcache_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/tb_clock.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f project.f --top-module dcache_tb -o dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "CHECKS FAILED" "$log"; then
    echo "simulation failed"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
